// ==== common/dma_cfg_pkg.sv ====
package dma_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // memory side widths
    ////////////////////////////////////////////////////////////////////////////

    // byte address into memory
    parameter int ADDR_W = 32;

    // one beat on both memory and stream side
    parameter int DATA_W = 64;

    ////////////////////////////////////////////////////////////////////////////
    // derived sizes
    ////////////////////////////////////////////////////////////////////////////

    parameter int BYTE_W     = DATA_W / 8;        // keep / strobe bits per beat
    parameter int BEAT_SHIFT = $clog2(BYTE_W);    // address step per beat, as shift

    // low address bits below BEAT_SHIFT are ignored by the engines,
    // every beat lands on its own aligned address

endpackage

// ==== common/dma_cmd_pkg.sv ====
package dma_cmd_pkg;

    import dma_cfg_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // command word
    ////////////////////////////////////////////////////////////////////////////

    // byte length sits in the low bits, start address above it
    parameter int LEN_W = 16;
    parameter int CMD_W = ADDR_W + LEN_W;

    // beat count of the longest command, length rounded up to whole beats
    parameter int BEAT_W = LEN_W - BEAT_SHIFT + 1;

    typedef logic [BEAT_W-1:0] beat_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // write response
    ////////////////////////////////////////////////////////////////////////////

    parameter int RESP_W = 2;

    // anything else on b is an error
    parameter logic [RESP_W-1:0] RESP_OKAY = 2'b00;

endpackage

// ==== src/dma_cmd_decode.sv ====
`timescale 1ns/1ps

module dma_cmd_decode #(
    parameter int ADDR_W = dma_cfg_pkg::ADDR_W
) (
    input  logic                          clk,
    input  logic                          rst,

    // user command, held until ack
    input  logic                          i_cmd_req,
    input  logic [dma_cmd_pkg::CMD_W-1:0] i_cmd_data,    // {saddr, byte len}
    output logic                          o_cmd_ack,

    // towards one engine
    output logic                          o_start,
    output logic [ADDR_W-1:0]             o_start_addr,
    output dma_cmd_pkg::beat_cnt_t        o_beats,
    input  logic                          i_done
);

    import dma_cfg_pkg::*;
    import dma_cmd_pkg::*;

    logic           busy;         // engine running
    logic [LEN_W:0] len_round;    // extra bit keeps the carry
    beat_cnt_t      cmd_beats;
    logic           take;
    logic           non_zero;

    // round byte length up to whole beats
    assign len_round = {1'b0, i_cmd_data[LEN_W-1:0]} + (LEN_W+1)'(BYTE_W - 1);
    assign cmd_beats = len_round[LEN_W:BEAT_SHIFT];
    assign non_zero  = (cmd_beats != '0);

    // req is still high in the ack cycle, so skip it there
    assign take = i_cmd_req & ~busy & ~o_cmd_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            o_cmd_ack <= 1'b0;
            o_start   <= 1'b0;
        end else begin
            o_cmd_ack <= take;
            o_start   <= take & non_zero;   // zero length only gets the ack
            if (take && non_zero) begin
                busy <= 1'b1;
            end else if (i_done) begin
                busy <= 1'b0;
            end
        end
    end

    // command fields, only looked at together with o_start
    always_ff @(posedge clk) begin
        if (take) begin
            o_start_addr <= i_cmd_data[LEN_W +: ADDR_W];
            o_beats      <= cmd_beats;
        end
    end

endmodule

// ==== mm2s/dma_mm2s_engine.sv ====
`timescale 1ns/1ps

module dma_mm2s_engine #(
    parameter int ADDR_W = dma_cfg_pkg::ADDR_W,
    parameter int DATA_W = dma_cfg_pkg::DATA_W
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   i_start,
    input  logic [ADDR_W-1:0]      i_start_addr,
    input  dma_cmd_pkg::beat_cnt_t i_beats,
    output logic                   o_done,

    // memory read address / data
    output logic                   o_mem_ar_valid,
    input  logic                   i_mem_ar_ready,
    output logic [ADDR_W-1:0]      o_mem_ar_addr,
    input  logic                   i_mem_r_valid,
    output logic                   o_mem_r_ready,
    input  logic [DATA_W-1:0]      i_mem_r_data,

    // outgoing stream
    output logic                   o_dma_rd_valid,
    input  logic                   i_dma_rd_ready,
    output logic [DATA_W-1:0]      o_dma_rd_data,
    output logic                   o_dma_rd_last
);

    import dma_cmd_pkg::*;

    localparam logic [ADDR_W-1:0] ADDR_STEP = ADDR_W'(DATA_W / 8);

    beat_cnt_t ar_left;     // addresses not yet issued
    beat_cnt_t r_left;      // words not yet returned
    logic      r_wait;      // one read outstanding
    logic      ar_fire;
    logic      r_fire;
    logic      out_fire;

    assign ar_fire  = o_mem_ar_valid & i_mem_ar_ready;
    assign r_fire   = i_mem_r_valid & o_mem_r_ready;
    assign out_fire = o_dma_rd_valid & i_dma_rd_ready;

    // take a word only if the buffer is free or empties this cycle
    assign o_mem_r_ready = r_wait & (~o_dma_rd_valid | i_dma_rd_ready);

    ////////////////////////////////////////////////////////////////////////////
    // address and read tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            o_mem_ar_valid <= 1'b0;
            r_wait         <= 1'b0;
            ar_left        <= '0;
            r_left         <= '0;
            o_dma_rd_valid <= 1'b0;
            o_dma_rd_last  <= 1'b0;
            o_done         <= 1'b0;
        end else begin
            o_done <= out_fire & o_dma_rd_last;
            if (i_start) begin
                o_mem_ar_valid <= 1'b1;
                ar_left        <= i_beats;
                r_left         <= i_beats;
            end
            if (ar_fire) begin
                o_mem_ar_valid <= 1'b0;
                r_wait         <= 1'b1;
                ar_left        <= ar_left - 1'b1;
            end
            if (r_fire) begin
                r_wait         <= 1'b0;
                r_left         <= r_left - 1'b1;
                o_mem_ar_valid <= (ar_left != '0);   // next address right away
                o_dma_rd_valid <= 1'b1;
                o_dma_rd_last  <= (r_left == beat_cnt_t'(1));
            end else if (out_fire) begin
                o_dma_rd_valid <= 1'b0;
                o_dma_rd_last  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            o_mem_ar_addr <= i_start_addr;
        end else if (ar_fire) begin
            o_mem_ar_addr <= o_mem_ar_addr + ADDR_STEP;
        end
        if (r_fire) begin
            o_dma_rd_data <= i_mem_r_data;  // one word buffer
        end
    end

endmodule

// ==== s2mm/dma_s2mm_engine.sv ====
`timescale 1ns/1ps

module dma_s2mm_engine #(
    parameter int ADDR_W = dma_cfg_pkg::ADDR_W,
    parameter int DATA_W = dma_cfg_pkg::DATA_W
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   i_start,
    input  logic [ADDR_W-1:0]      i_start_addr,
    input  dma_cmd_pkg::beat_cnt_t i_beats,
    output logic                   o_done,

    // incoming stream
    input  logic                   i_dma_wr_valid,
    output logic                   o_dma_wr_ready,
    input  logic [DATA_W-1:0]      i_dma_wr_data,
    input  logic [DATA_W/8-1:0]    i_dma_wr_keep,

    // memory write address / data
    output logic                   o_mem_aw_valid,
    input  logic                   i_mem_aw_ready,
    output logic [ADDR_W-1:0]      o_mem_aw_addr,
    output logic                   o_mem_w_valid,
    input  logic                   i_mem_w_ready,
    output logic [DATA_W-1:0]      o_mem_w_data,
    output logic [DATA_W/8-1:0]    o_mem_w_strb
);

    import dma_cmd_pkg::*;

    localparam logic [ADDR_W-1:0] ADDR_STEP = ADDR_W'(DATA_W / 8);

    beat_cnt_t beats_left;
    logic      active;
    logic      aw_hold;         // aw still waiting after this cycle
    logic      w_hold;
    logic      beat_taken;      // both channels done with the beat
    logic      in_fire;

    assign aw_hold    = o_mem_aw_valid & ~i_mem_aw_ready;
    assign w_hold     = o_mem_w_valid & ~i_mem_w_ready;
    assign beat_taken = (o_mem_aw_valid | o_mem_w_valid) & ~aw_hold & ~w_hold;

    // one beat held at a time, ready stays low while memory stalls
    assign o_dma_wr_ready = active & ~o_mem_aw_valid & ~o_mem_w_valid;
    assign in_fire        = i_dma_wr_valid & o_dma_wr_ready;

    ////////////////////////////////////////////////////////////////////////////
    // beat control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            active         <= 1'b0;
            beats_left     <= '0;
            o_mem_aw_valid <= 1'b0;
            o_mem_w_valid  <= 1'b0;
            o_done         <= 1'b0;
        end else begin
            o_done         <= 1'b0;
            o_mem_aw_valid <= in_fire | aw_hold;
            o_mem_w_valid  <= in_fire | w_hold;
            if (i_start) begin
                active     <= 1'b1;
                beats_left <= i_beats;
            end else if (beat_taken) begin
                beats_left <= beats_left - 1'b1;
                if (beats_left == beat_cnt_t'(1)) begin
                    active <= 1'b0;
                    o_done <= 1'b1;     // last beat accepted by memory
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            o_mem_aw_addr <= i_start_addr;
        end else if (beat_taken) begin
            o_mem_aw_addr <= o_mem_aw_addr + ADDR_STEP;
        end
        if (in_fire) begin
            o_mem_w_data <= i_dma_wr_data;
            o_mem_w_strb <= i_dma_wr_keep;  // keep maps straight to strobe
        end
    end

endmodule

// ==== s2mm/dma_wr_resp_track.sv ====
`timescale 1ns/1ps

module dma_wr_resp_track (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           i_start,
    input  dma_cmd_pkg::beat_cnt_t         i_beats,

    input  logic                           i_mem_b_valid,
    output logic                           o_mem_b_ready,
    input  logic [dma_cmd_pkg::RESP_W-1:0] i_mem_b_resp,

    output logic                           o_wr_finish,
    output logic                           o_wr_error
);

    import dma_cmd_pkg::*;

    beat_cnt_t resp_left;   // responses still expected
    logic      err_seen;
    logic      bad_resp;

    assign o_mem_b_ready = 1'b1;    // responses never stalled
    assign bad_resp      = (i_mem_b_resp != RESP_OKAY);

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_left   <= '0;
            err_seen    <= 1'b0;
            o_wr_finish <= 1'b0;
            o_wr_error  <= 1'b0;
        end else begin
            o_wr_finish <= 1'b0;
            o_wr_error  <= 1'b0;
            if (i_start) begin
                resp_left <= i_beats;
                err_seen  <= 1'b0;
            end else if (i_mem_b_valid && resp_left != '0) begin
                resp_left <= resp_left - 1'b1;
                if (resp_left == beat_cnt_t'(1)) begin
                    o_wr_finish <= 1'b1;
                    o_wr_error  <= err_seen | bad_resp;
                    err_seen    <= 1'b0;
                end else begin
                    err_seen <= err_seen | bad_resp;
                end
            end
        end
    end

endmodule

// ==== src/dma_top.sv ====
`timescale 1ns/1ps

module dma_top #(
    parameter int ADDR_W = dma_cfg_pkg::ADDR_W,
    parameter int DATA_W = dma_cfg_pkg::DATA_W
) (
    input  logic                           clk,
    input  logic                           rst,

    // commands
    input  logic                           i_rd_cmd_req,
    input  logic [dma_cmd_pkg::CMD_W-1:0]  i_rd_cmd_data,
    output logic                           o_rd_cmd_ack,
    input  logic                           i_wr_cmd_req,
    input  logic [dma_cmd_pkg::CMD_W-1:0]  i_wr_cmd_data,
    output logic                           o_wr_cmd_ack,

    // streams
    output logic                           o_dma_rd_valid,
    input  logic                           i_dma_rd_ready,
    output logic [DATA_W-1:0]              o_dma_rd_data,
    output logic                           o_dma_rd_last,
    input  logic                           i_dma_wr_valid,
    output logic                           o_dma_wr_ready,
    input  logic [DATA_W-1:0]              i_dma_wr_data,
    input  logic [DATA_W/8-1:0]            i_dma_wr_keep,
    output logic                           o_wr_finish,
    output logic                           o_wr_error,

    // memory
    output logic                           o_mem_ar_valid,
    input  logic                           i_mem_ar_ready,
    output logic [ADDR_W-1:0]              o_mem_ar_addr,
    input  logic                           i_mem_r_valid,
    output logic                           o_mem_r_ready,
    input  logic [DATA_W-1:0]              i_mem_r_data,
    output logic                           o_mem_aw_valid,
    input  logic                           i_mem_aw_ready,
    output logic [ADDR_W-1:0]              o_mem_aw_addr,
    output logic                           o_mem_w_valid,
    input  logic                           i_mem_w_ready,
    output logic [DATA_W-1:0]              o_mem_w_data,
    output logic [DATA_W/8-1:0]            o_mem_w_strb,
    input  logic                           i_mem_b_valid,
    output logic                           o_mem_b_ready,
    input  logic [dma_cmd_pkg::RESP_W-1:0] i_mem_b_resp
);

    import dma_cmd_pkg::*;

    logic              rd_start, rd_done;
    logic [ADDR_W-1:0] rd_start_addr;
    beat_cnt_t         rd_beats;
    logic              wr_start, wr_done;
    logic [ADDR_W-1:0] wr_start_addr;
    beat_cnt_t         wr_beats;

    ////////////////////////////////////////////////////////////////////////////
    // read path, memory to stream
    ////////////////////////////////////////////////////////////////////////////

    dma_cmd_decode #(.ADDR_W(ADDR_W)) u_rd_decode (
        .clk, .rst,
        .i_cmd_req (i_rd_cmd_req), .i_cmd_data (i_rd_cmd_data), .o_cmd_ack (o_rd_cmd_ack),
        .o_start (rd_start), .o_start_addr (rd_start_addr), .o_beats (rd_beats),
        .i_done (rd_done)
    );

    dma_mm2s_engine #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_mm2s (
        .clk, .rst,
        .i_start (rd_start), .i_start_addr (rd_start_addr), .i_beats (rd_beats),
        .o_done (rd_done),
        .o_mem_ar_valid, .i_mem_ar_ready, .o_mem_ar_addr,
        .i_mem_r_valid, .o_mem_r_ready, .i_mem_r_data,
        .o_dma_rd_valid, .i_dma_rd_ready, .o_dma_rd_data, .o_dma_rd_last
    );

    ////////////////////////////////////////////////////////////////////////////
    // write path, stream to memory
    ////////////////////////////////////////////////////////////////////////////

    dma_cmd_decode #(.ADDR_W(ADDR_W)) u_wr_decode (
        .clk, .rst,
        .i_cmd_req (i_wr_cmd_req), .i_cmd_data (i_wr_cmd_data), .o_cmd_ack (o_wr_cmd_ack),
        .o_start (wr_start), .o_start_addr (wr_start_addr), .o_beats (wr_beats),
        .i_done (wr_done)
    );

    dma_s2mm_engine #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_s2mm (
        .clk, .rst,
        .i_start (wr_start), .i_start_addr (wr_start_addr), .i_beats (wr_beats),
        .o_done (wr_done),
        .i_dma_wr_valid, .o_dma_wr_ready, .i_dma_wr_data, .i_dma_wr_keep,
        .o_mem_aw_valid, .i_mem_aw_ready, .o_mem_aw_addr,
        .o_mem_w_valid, .i_mem_w_ready, .o_mem_w_data, .o_mem_w_strb
    );

    // finish follows the last b, not the last w
    dma_wr_resp_track u_wr_resp (
        .clk, .rst,
        .i_start (wr_start), .i_beats (wr_beats),
        .i_mem_b_valid, .o_mem_b_ready, .i_mem_b_resp,
        .o_wr_finish, .o_wr_error
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD = 50,     // 100 ns clock
    parameter int RST_CYCLES  = 10
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // release just after an edge, like every other tb input
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1;
        o_rst = 1'b0;
    end

endmodule

// ==== dv/tb_mem_slave.sv ====
`timescale 1ns/1ps

module tb_mem_slave #(
    parameter int ADDR_W    = 32,
    parameter int DATA_W    = 64,
    parameter int MEM_WORDS = 512
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_stall,        // random ready / valid gaps
    input  logic [ADDR_W-1:0]   i_err_addr,     // a write here gets an error code
    input  logic                i_ar_valid,
    output logic                o_ar_ready,
    input  logic [ADDR_W-1:0]   i_ar_addr,
    output logic                o_r_valid,
    input  logic                i_r_ready,
    output logic [DATA_W-1:0]   o_r_data,
    input  logic                i_aw_valid,
    output logic                o_aw_ready,
    input  logic [ADDR_W-1:0]   i_aw_addr,
    input  logic                i_w_valid,
    output logic                o_w_ready,
    input  logic [DATA_W-1:0]   i_w_data,
    input  logic [DATA_W/8-1:0] i_w_strb,
    output logic                o_b_valid,
    input  logic                i_b_ready,
    output logic [1:0]          o_b_resp
);

    localparam int SHIFT  = $clog2(DATA_W / 8);
    localparam int MEM_AW = $clog2(MEM_WORDS);

    logic [DATA_W-1:0]   mem [0:MEM_WORDS-1];
    logic [1:0]          b_queue [$];       // responses not sent yet
    logic [ADDR_W-1:0]   rd_addr;
    logic [ADDR_W-1:0]   wr_addr;
    logic [DATA_W-1:0]   wr_data;
    logic [DATA_W/8-1:0] wr_strb;
    logic                rd_pend;
    logic                aw_got;
    logic                w_got;
    int                  rd_delay;

    function automatic logic take_chance();
        return !i_stall || ($urandom_range(0, 3) != 0);
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = DATA_W'({~32'(i), 32'h5a5a_0000 ^ 32'(i)});   // whole index in both halves
        end
        {o_ar_ready, o_r_valid, o_aw_ready, o_w_ready, o_b_valid} = '0;
        o_r_data = '0;
        o_b_resp = 2'b00;
        {rd_pend, aw_got, w_got} = '0;
        rd_delay = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            {rd_pend, aw_got, w_got} = '0;
            b_queue.delete();
        end else begin
            if (o_b_valid && i_b_ready) begin
                void'(b_queue.pop_front());
            end
            if (o_r_valid && i_r_ready) begin
                rd_pend = 1'b0;
            end
            if (i_ar_valid && o_ar_ready) begin
                rd_addr  = i_ar_addr;
                rd_pend  = 1'b1;
                rd_delay = i_stall ? $urandom_range(0, 4) : 0;
            end else if (rd_delay > 0) begin
                rd_delay--;
            end
            if (i_aw_valid && o_aw_ready) begin
                wr_addr = i_aw_addr;
                aw_got  = 1'b1;
            end
            if (i_w_valid && o_w_ready) begin
                wr_data = i_w_data;
                wr_strb = i_w_strb;
                w_got   = 1'b1;
            end
            // a beat is written once both address and data are in
            if (aw_got && w_got) begin
                for (int b = 0; b < DATA_W / 8; b++) begin
                    if (wr_strb[b]) begin
                        mem[wr_addr[SHIFT +: MEM_AW]][8*b +: 8] = wr_data[8*b +: 8];
                    end
                end
                b_queue.push_back((wr_addr == i_err_addr) ? 2'b10 : 2'b00);
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
        end
        #1;
        o_ar_ready = !rst && !rd_pend && take_chance();
        o_aw_ready = !rst && !aw_got && take_chance();
        o_w_ready  = !rst && !w_got && take_chance();
        o_r_valid  = rd_pend && (rd_delay == 0);
        o_r_data   = rd_pend ? mem[rd_addr[SHIFT +: MEM_AW]] : '0;
        o_b_valid  = (b_queue.size() != 0) && take_chance();
        o_b_resp   = (b_queue.size() != 0) ? b_queue[0] : 2'b00;
    end

endmodule

// ==== dv/tb_dma.sv ====
`timescale 1ns/1ps

module tb_dma;

    import dma_cfg_pkg::*;
    import dma_cmd_pkg::*;

    localparam int TIMEOUT   = 1000;    // cycles allowed for each wait
    localparam int MEM_WORDS = 512;
    localparam int N_WRITES  = 10;
    localparam int ERR_CMD   = 3;       // this write meets the error address

    logic              clk, rst;
    logic              i_rd_cmd_req, o_rd_cmd_ack, i_wr_cmd_req, o_wr_cmd_ack;
    logic [CMD_W-1:0]  i_rd_cmd_data, i_wr_cmd_data;
    logic              o_dma_rd_valid, i_dma_rd_ready, o_dma_rd_last;
    logic              i_dma_wr_valid, o_dma_wr_ready, o_wr_finish, o_wr_error;
    logic [DATA_W-1:0] o_dma_rd_data, i_dma_wr_data, i_mem_r_data, o_mem_w_data;
    logic [BYTE_W-1:0] i_dma_wr_keep, o_mem_w_strb;
    logic              o_mem_ar_valid, i_mem_ar_ready, i_mem_r_valid, o_mem_r_ready;
    logic              o_mem_aw_valid, i_mem_aw_ready, o_mem_w_valid, i_mem_w_ready;
    logic              i_mem_b_valid, o_mem_b_ready;
    logic [ADDR_W-1:0] o_mem_ar_addr, o_mem_aw_addr, err_addr;
    logic [RESP_W-1:0] i_mem_b_resp;
    logic              stall;

    logic [DATA_W-1:0] model [0:MEM_WORDS-1];
    logic [ADDR_W-1:0] area_addr [$];       // written areas to read back later
    int                area_len [$];
    int                val_errs, to_errs;
    int                finish_cnt, exp_finish, rd_beat_cnt, exp_rd_beats;

    tb_clk_gen u_clk (.o_clk(clk), .o_rst(rst));

    dma_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_dut (.*);

    tb_mem_slave #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .MEM_WORDS(MEM_WORDS)) u_mem (
        .clk, .rst, .i_stall(stall), .i_err_addr(err_addr),
        .i_ar_valid(o_mem_ar_valid), .o_ar_ready(i_mem_ar_ready), .i_ar_addr(o_mem_ar_addr),
        .o_r_valid(i_mem_r_valid), .i_r_ready(o_mem_r_ready), .o_r_data(i_mem_r_data),
        .i_aw_valid(o_mem_aw_valid), .o_aw_ready(i_mem_aw_ready), .i_aw_addr(o_mem_aw_addr),
        .i_w_valid(o_mem_w_valid), .o_w_ready(i_mem_w_ready), .i_w_data(o_mem_w_data),
        .i_w_strb(o_mem_w_strb),
        .o_b_valid(i_mem_b_valid), .i_b_ready(o_mem_b_ready), .o_b_resp(i_mem_b_resp)
    );

    // totals compared at the end to catch stray pulses or beats
    always @(posedge clk) begin
        if (!rst && o_wr_finish) finish_cnt++;
        if (!rst && o_dma_rd_valid && i_dma_rd_ready) rd_beat_cnt++;
        // b is never back-pressured
        if (!rst && o_mem_b_ready !== 1'b1) report_mismatch("o_mem_b_ready", 1, o_mem_b_ready);
    end

    ////////////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp_val,
                                   input logic [DATA_W-1:0] act_val);
        val_errs++;
        $display("FAIL %0t ns %s expected %h actual %h", $time, name, exp_val, act_val);
    endtask

    task automatic finish_run();
        $display("errors: %0d wrong values, %0d timeouts", val_errs, to_errs);
        if (val_errs == 0 && to_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic count_timeout(input string what);
        to_errs++;
        $display("Timed out at %0t ns waiting for %s", $time, what);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks start and end 1 ns after a rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_cmd(input bit is_wr, input logic [ADDR_W-1:0] addr, input int len);
        int t;
        bit acked;
        t     = 0;
        acked = 1'b0;
        if (is_wr) begin
            i_wr_cmd_req  = 1'b1;
            i_wr_cmd_data = {addr, LEN_W'(len)};
        end else begin
            i_rd_cmd_req  = 1'b1;
            i_rd_cmd_data = {addr, LEN_W'(len)};
        end
        while (!acked && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            acked = is_wr ? o_wr_cmd_ack : o_rd_cmd_ack;
        end
        #1;
        i_wr_cmd_req = 1'b0;
        i_rd_cmd_req = 1'b0;
        if (!acked) count_timeout("command acknowledge");
    endtask

    task automatic run_write(input logic [ADDR_W-1:0] addr, input int len, input bit exp_err);
        int                beats;
        int                idx;
        int                t;
        bit                got;
        logic [DATA_W-1:0] data;
        logic [BYTE_W-1:0] keep;
        beats = (len + BYTE_W - 1) / BYTE_W;
        send_cmd(1'b1, addr, len);
        for (int n = 0; n < beats; n++) begin
            data           = DATA_W'({$urandom, $urandom});
            keep           = BYTE_W'($urandom);
            i_dma_wr_valid = 1'b1;
            i_dma_wr_data  = data;
            i_dma_wr_keep  = keep;
            got            = 1'b0;
            t              = 0;
            while (!got && t < TIMEOUT) begin
                @(posedge clk);
                t++;
                got = o_dma_wr_ready;
            end
            #1;
            i_dma_wr_valid = 1'b0;
            if (!got) count_timeout("o_dma_wr_ready");
            idx = int'(addr >> BEAT_SHIFT) + n;
            for (int b = 0; b < BYTE_W; b++) begin
                if (keep[b]) model[idx][8*b +: 8] = data[8*b +: 8];   // cleared keep leaves byte
            end
        end
        got = 1'b0;
        t   = 0;
        while (!got && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            if (o_wr_finish) begin
                got = 1'b1;
                if (o_wr_error !== exp_err) report_mismatch("o_wr_error", exp_err, o_wr_error);
            end
        end
        #1;
        if (!got) count_timeout("o_wr_finish");
        exp_finish++;
    endtask

    task automatic run_read(input logic [ADDR_W-1:0] addr, input int len, input bit rand_ready);
        int                beats;
        int                got;
        int                idx;
        int                t;
        bit                hold;
        logic [DATA_W-1:0] held;
        beats = (len + BYTE_W - 1) / BYTE_W;
        got   = 0;
        t     = 0;
        hold  = 1'b0;
        held  = '0;
        send_cmd(1'b0, addr, len);
        while (got < beats && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            if (hold && !o_dma_rd_valid) begin
                report_mismatch("o_dma_rd_valid while stalled", 1, o_dma_rd_valid);
            end else if (hold && o_dma_rd_data !== held) begin
                report_mismatch("o_dma_rd_data while stalled", held, o_dma_rd_data);
            end
            if (o_dma_rd_valid && i_dma_rd_ready) begin
                idx = int'(addr >> BEAT_SHIFT) + got;
                if (o_dma_rd_data !== model[idx]) begin
                    report_mismatch("o_dma_rd_data", model[idx], o_dma_rd_data);
                end
                if (o_dma_rd_last !== (got == beats - 1)) begin
                    report_mismatch("o_dma_rd_last", (got == beats - 1), o_dma_rd_last);
                end
                got++;
                t = 0;
            end
            hold = o_dma_rd_valid && !i_dma_rd_ready;
            held = o_dma_rd_data;
            #1;
            i_dma_rd_ready = rand_ready ? ($urandom_range(0, 2) != 0) : 1'b1;
        end
        if (got < beats) count_timeout("read stream beats");
        exp_rd_beats += beats;
    endtask

    // nothing may move after reset or after a zero length command
    task automatic check_quiet(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            if (o_rd_cmd_ack !== 1'b0) report_mismatch("o_rd_cmd_ack", 0, o_rd_cmd_ack);
            if (o_wr_cmd_ack !== 1'b0) report_mismatch("o_wr_cmd_ack", 0, o_wr_cmd_ack);
            if (o_wr_finish !== 1'b0) report_mismatch("o_wr_finish", 0, o_wr_finish);
            if (o_wr_error !== 1'b0) report_mismatch("o_wr_error", 0, o_wr_error);
            if (o_dma_rd_valid !== 1'b0) report_mismatch("o_dma_rd_valid", 0, o_dma_rd_valid);
            if (o_dma_wr_ready !== 1'b0) report_mismatch("o_dma_wr_ready", 0, o_dma_wr_ready);
            if (o_mem_ar_valid !== 1'b0) report_mismatch("o_mem_ar_valid", 0, o_mem_ar_valid);
            if (o_mem_aw_valid !== 1'b0) report_mismatch("o_mem_aw_valid", 0, o_mem_aw_valid);
            if (o_mem_w_valid !== 1'b0) report_mismatch("o_mem_w_valid", 0, o_mem_w_valid);
            #1;
        end
    endtask

    initial begin
        int                t;
        int                len;
        int                err_beat;
        logic [ADDR_W-1:0] addr;
        void'($urandom(32'h41c959c1));
        {val_errs, to_errs, finish_cnt, exp_finish, rd_beat_cnt, exp_rd_beats} = '0;
        {i_rd_cmd_req, i_wr_cmd_req, i_dma_rd_ready, i_dma_wr_valid, stall} = '0;
        i_rd_cmd_data = '0;
        i_wr_cmd_data = '0;
        i_dma_wr_data = '0;
        i_dma_wr_keep = '0;
        err_addr      = '1;    // never beat aligned so no error
        for (int i = 0; i < MEM_WORDS; i++) begin
            model[i] = DATA_W'({~32'(i), 32'h5a5a_0000 ^ 32'(i)});
        end
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (rst && t < TIMEOUT);
        #1;
        if (rst) count_timeout("reset release");
        check_quiet(3);

        // random writes with memory stalls in the second half
        for (int i = 0; i < N_WRITES; i++) begin
            addr  = ADDR_W'($urandom_range(0, MEM_WORDS - 17)) << BEAT_SHIFT;
            len   = $urandom_range(1, 128);
            stall = (i >= N_WRITES / 2);
            if (i == ERR_CMD) begin
                err_beat = $urandom_range(0, (len + BYTE_W - 1) / BYTE_W - 1);
                err_addr = addr + ADDR_W'(err_beat * BYTE_W);
            end
            run_write(addr, len, i == ERR_CMD);
            err_addr = '1;
            area_addr.push_back(addr);
            area_len.push_back(len);
        end

        // zero length commands only get the ack
        send_cmd(1'b1, ADDR_W'(64), 0);
        check_quiet(20);
        send_cmd(1'b0, ADDR_W'(64), 0);
        check_quiet(20);

        stall = 1'b0;
        foreach (area_addr[i]) run_read(area_addr[i], area_len[i], 1'b0);
        stall = 1'b1;
        foreach (area_addr[i]) run_read(area_addr[i], area_len[i], 1'b1);

        for (int i = 0; i < MEM_WORDS; i++) begin
            if (u_mem.mem[i] !== model[i]) begin
                report_mismatch($sformatf("mem[%0d]", i), model[i], u_mem.mem[i]);
            end
        end
        if (finish_cnt != exp_finish) report_mismatch("o_wr_finish count", exp_finish, finish_cnt);
        if (rd_beat_cnt != exp_rd_beats) begin
            report_mismatch("read beat count", exp_rd_beats, rd_beat_cnt);
        end
        finish_run();
    end

endmodule

// ==== dma_mover.f ====
common/dma_cfg_pkg.sv
common/dma_cmd_pkg.sv
src/dma_cmd_decode.sv
mm2s/dma_mm2s_engine.sv
s2mm/dma_s2mm_engine.sv
s2mm/dma_wr_resp_track.sv
src/dma_top.sv
dv/tb_clk_gen.sv
dv/tb_mem_slave.sv
dv/tb_dma.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the DMA mover testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_dma \
    -f dma_mover.f -Mdir "$BUILD_DIR" -o tb_dma_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_dma_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "result: FAIL"
    exit 1
fi
echo "result: PASS"
exit 0
